// ==== logic/pcxt_ctrl_pkg.sv ====
/*
 * PC/XT system control package
 * Clock rates, reset and splash counts, download widths and state types
 */
package pcxt_ctrl_pkg;

	// Main clock
	localparam logic [31:0] SYS_CLOCK_HZ = 32'd50_000_000;

	// Phase steps for the enable accumulators
	localparam logic [31:0] AUDIO_RATE_HZ      = 32'd44_100;
	localparam logic [31:0] CPU_RATE_4M77_HZ   = 32'd4_772_727;
	localparam logic [31:0] CPU_RATE_7M16_HZ   = 32'd7_159_090;
	localparam logic [31:0] CPU_RATE_14M318_HZ = 32'd14_318_181;

	// CPU speed select, code 3 runs as 4.77
	typedef enum logic [1:0] {
		SPEED_4M77   = 2'd0,
		SPEED_7M16   = 2'd1,
		SPEED_14M318 = 2'd2
	} cpu_speed_t;

	// Reset stretch and CPU release delay
	localparam logic [15:0] RESET_HOLD_CYCLES = 16'd65_535;
	localparam logic [15:0] CPU_RESET_DELAY   = 16'd42;

	// Splash screen timing
	localparam logic [3:0]  SPLASH_SECONDS             = 4'd5;
	localparam logic [31:0] SPLASH_TICK_CYCLES_DEFAULT = 32'd50_000_000;

	// Download bus widths
	localparam int ROM_ADDR_W = 25;
	localparam int ROM_WORD_W = 16;
	localparam int ROM_BYTE_W = 8;

	typedef enum logic [1:0] {DL_IDLE, DL_HIGH, DL_DRAIN} download_state_t;

endpackage

// ==== logic/rom_download_splitter.sv ====
/*
 * ROM download splitter
 * Turns each 16-bit loader word into two byte writes and stalls the loader
 */
`timescale 1ns/1ps

module rom_download_splitter (
	input  logic                                 CLK_50M,
	input  logic                                 reset_wire,
	input  logic                                 ioctl_wr,
	input  logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0] ioctl_addr,
	input  logic [pcxt_ctrl_pkg::ROM_WORD_W-1:0] ioctl_data,
	output logic                                 ioctl_wait,
	output logic                                 rom_wr,
	output logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic [pcxt_ctrl_pkg::ROM_BYTE_W-1:0] rom_data
);

	pcxt_ctrl_pkg::download_state_t dl_state;

	// Word captured from the loader
	logic                                 word_valid;
	logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0] word_addr;
	logic [pcxt_ctrl_pkg::ROM_WORD_W-1:0] word_data;

	logic take_word;
	logic emit_low;
	logic emit_high;

	// Only a fresh strobe in idle is taken
	assign take_word = (dl_state == pcxt_ctrl_pkg::DL_IDLE) && !word_valid && ioctl_wr;
	// Low byte goes out the cycle after capture
	assign emit_low  = (dl_state == pcxt_ctrl_pkg::DL_IDLE) && word_valid;
	assign emit_high = (dl_state == pcxt_ctrl_pkg::DL_HIGH);

	////////////////////////////////////////////////////////////////////////////
	// State machine
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			dl_state   <= pcxt_ctrl_pkg::DL_IDLE;
			word_valid <= 1'b0;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			// Loader held off for both byte writes
			rom_wr     <= emit_low || emit_high;
			ioctl_wait <= emit_low || emit_high;
			case (dl_state)
				pcxt_ctrl_pkg::DL_IDLE: begin
					if (take_word) begin
						word_valid <= 1'b1;
					end else if (word_valid) begin
						word_valid <= 1'b0;
						dl_state   <= pcxt_ctrl_pkg::DL_HIGH;
					end
				end
				pcxt_ctrl_pkg::DL_HIGH: begin
					dl_state <= pcxt_ctrl_pkg::DL_DRAIN;
				end
				pcxt_ctrl_pkg::DL_DRAIN: begin
					// Wait out a held strobe so a word writes once
					if (!ioctl_wr)
						dl_state <= pcxt_ctrl_pkg::DL_IDLE;
				end
				default: begin
					dl_state <= pcxt_ctrl_pkg::DL_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Word and byte datapath
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			word_addr <= '0;
			word_data <= '0;
			rom_addr  <= '0;
			rom_data  <= '0;
		end else begin
			if (take_word) begin
				word_addr <= ioctl_addr;
				word_data <= ioctl_data;
			end
			if (emit_low) begin
				rom_addr <= word_addr;
				rom_data <= word_data[pcxt_ctrl_pkg::ROM_BYTE_W-1:0];
			end else if (emit_high) begin
				// High byte lands at the odd address
				rom_addr <= word_addr + 1'b1;
				rom_data <= word_data[pcxt_ctrl_pkg::ROM_WORD_W-1:pcxt_ctrl_pkg::ROM_BYTE_W];
			end
		end
	end

	// Loader held for exactly one pair of byte writes
	a_wait_covers_wr: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		$rose(ioctl_wait) |-> rom_wr ##1 (rom_wr && ioctl_wait) ##1 (!rom_wr && !ioctl_wait));

	// Second write of a pair steps the address by one
	a_pair_addr_step: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		(rom_wr && dl_state == pcxt_ctrl_pkg::DL_HIGH)
		|=> (rom_wr && rom_addr == $past(rom_addr) + 1'b1));

endmodule

// ==== logic/reset_sequencer.sv ====
/*
 * Reset sequencer
 * Stretches reset requests, delays the CPU release, latches the machine model
 */
`timescale 1ns/1ps

module reset_sequencer (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic menu_reset,
	input  logic splash_active,
	input  logic model_tandy,
	output logic sys_reset,
	output logic cpu_reset,
	output logic tandy_mode
);

	logic        request;
	logic [15:0] hold_cnt;
	logic [15:0] cpu_cnt;

	// Menu reset or splash hold restarts the stretch
	assign request = menu_reset || splash_active;

	////////////////////////////////////////////////////////////////////////////
	// System reset stretch
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			hold_cnt  <= '0;
		end else if (request) begin
			sys_reset <= 1'b1;
			hold_cnt  <= '0;
		end else if (sys_reset) begin
			// Last hold cycle
			if (hold_cnt == pcxt_ctrl_pkg::RESET_HOLD_CYCLES - 16'd1)
				sys_reset <= 1'b0;
			hold_cnt <= hold_cnt + 16'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// CPU reset trails system reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			cpu_cnt   <= '0;
		end else if (request || sys_reset) begin
			// Rises together with a new request
			cpu_reset <= 1'b1;
			cpu_cnt   <= '0;
		end else if (cpu_reset) begin
			if (cpu_cnt == pcxt_ctrl_pkg::CPU_RESET_DELAY - 16'd1)
				cpu_reset <= 1'b0;
			cpu_cnt <= cpu_cnt + 16'd1;
		end
	end

	// Model follows the switch only while the machine sits in reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			tandy_mode <= 1'b0;
		else if (sys_reset)
			tandy_mode <= model_tandy;
	end

	// CPU stays in reset whenever the system does
	a_cpu_under_sys: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset);

endmodule

// ==== logic/clock_enable_gen.sv ====
/*
 * Clock enable generator
 * Fractional accumulators for the 44.1 kHz audio and selectable CPU enables
 */
`timescale 1ns/1ps

module clock_enable_gen (
	input  logic                      CLK_50M,
	input  logic                      reset_wire,
	input  pcxt_ctrl_pkg::cpu_speed_t cpu_speed,
	input  logic                      biu_done,
	output logic                      audio_ce,
	output logic                      cpu_ce,
	output logic                      turbo_mode
);

	// Speed in force for the CPU accumulator
	pcxt_ctrl_pkg::cpu_speed_t speed_q;

	logic [31:0] audio_acc;
	logic [31:0] audio_sum;
	logic [31:0] cpu_acc;
	logic [31:0] cpu_sum;
	logic [31:0] cpu_step;

	////////////////////////////////////////////////////////////////////////////
	// Speed latch
	// Switch only on a finished bus cycle
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			speed_q <= pcxt_ctrl_pkg::SPEED_4M77;
		else if (biu_done)
			speed_q <= cpu_speed;
	end

	// Step per speed, spare code runs at 4.77
	always_comb begin
		case (speed_q)
			pcxt_ctrl_pkg::SPEED_7M16:   cpu_step = pcxt_ctrl_pkg::CPU_RATE_7M16_HZ;
			pcxt_ctrl_pkg::SPEED_14M318: cpu_step = pcxt_ctrl_pkg::CPU_RATE_14M318_HZ;
			default:                     cpu_step = pcxt_ctrl_pkg::CPU_RATE_4M77_HZ;
		endcase
	end

	assign turbo_mode = (speed_q == pcxt_ctrl_pkg::SPEED_7M16)
		|| (speed_q == pcxt_ctrl_pkg::SPEED_14M318);

	assign audio_sum = audio_acc + pcxt_ctrl_pkg::AUDIO_RATE_HZ;
	assign cpu_sum   = cpu_acc + cpu_step;

	////////////////////////////////////////////////////////////////////////////
	// Phase accumulators
	// Wrap past the system rate emits one enable
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			audio_acc <= '0;
			audio_ce  <= 1'b0;
		end else if (audio_sum >= pcxt_ctrl_pkg::SYS_CLOCK_HZ) begin
			audio_acc <= audio_sum - pcxt_ctrl_pkg::SYS_CLOCK_HZ;
			audio_ce  <= 1'b1;
		end else begin
			audio_acc <= audio_sum;
			audio_ce  <= 1'b0;
		end
	end

	// CPU side, step may change between wraps
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_acc <= '0;
			cpu_ce  <= 1'b0;
		end else if (cpu_sum >= pcxt_ctrl_pkg::SYS_CLOCK_HZ) begin
			cpu_acc <= cpu_sum - pcxt_ctrl_pkg::SYS_CLOCK_HZ;
			cpu_ce  <= 1'b1;
		end else begin
			cpu_acc <= cpu_sum;
			cpu_ce  <= 1'b0;
		end
	end

	// Residues stay below one full period
	a_acc_in_range: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		(audio_acc < pcxt_ctrl_pkg::SYS_CLOCK_HZ) && (cpu_acc < pcxt_ctrl_pkg::SYS_CLOCK_HZ));

endmodule

// ==== logic/splash_timer.sv ====
/*
 * Splash timer
 * Holds the splash for a fixed number of seconds unless skipped
 */
`timescale 1ns/1ps

module splash_timer #(
	parameter logic [31:0] SPLASH_TICK_CYCLES = pcxt_ctrl_pkg::SPLASH_TICK_CYCLES_DEFAULT
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic splash_skip,
	output logic splash_active
);

	logic [31:0] tick_cnt;
	logic [3:0]  sec_cnt;

	// Counters freeze once the splash is over
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (splash_skip) begin
				// User asked to skip
				splash_active <= 1'b0;
			end else if (tick_cnt == SPLASH_TICK_CYCLES - 32'd1) begin
				// One second done
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 4'd1;
				if (sec_cnt == pcxt_ctrl_pkg::SPLASH_SECONDS - 4'd1)
					splash_active <= 1'b0;
			end else begin
				tick_cnt <= tick_cnt + 32'd1;
			end
		end
	end

	// Splash ends for good until the next reset
	a_splash_once: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!splash_active |=> !splash_active);

endmodule

// ==== logic/pcxt_system_ctrl.sv ====
/*
 * PC/XT system control
 * ROM download, reset sequencing, clock enables and the splash hold
 */
`timescale 1ns/1ps

module pcxt_system_ctrl #(
	parameter logic [31:0] SPLASH_TICK_CYCLES = pcxt_ctrl_pkg::SPLASH_TICK_CYCLES_DEFAULT
) (
	input  logic                                 CLK_50M,
	input  logic                                 reset_wire,
	// Loader side
	input  logic                                 ioctl_wr,
	input  logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0] ioctl_addr,
	input  logic [pcxt_ctrl_pkg::ROM_WORD_W-1:0] ioctl_data,
	output logic                                 ioctl_wait,
	// Byte writes toward the ROM
	output logic                                 rom_wr,
	output logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic [pcxt_ctrl_pkg::ROM_BYTE_W-1:0] rom_data,
	// Menu options
	input  logic                                 splash_skip,
	input  logic                                 menu_reset,
	input  logic                                 model_tandy,
	input  pcxt_ctrl_pkg::cpu_speed_t            cpu_speed,
	// From the CPU bus unit
	input  logic                                 biu_done,
	output logic                                 splash_active,
	output logic                                 sys_reset,
	output logic                                 cpu_reset,
	output logic                                 tandy_mode,
	output logic                                 audio_ce,
	output logic                                 cpu_ce,
	output logic                                 turbo_mode
);

	////////////////////////////////////////////////////////////////////////////
	// Input side
	rom_download_splitter u_download_splitter (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_data (ioctl_data),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reset and enables
	// Splash hold feeds the reset request
	reset_sequencer u_reset_sequencer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.menu_reset    (menu_reset),
		.splash_active (splash_active),
		.model_tandy   (model_tandy),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.tandy_mode    (tandy_mode)
	);

	clock_enable_gen u_clock_enable_gen (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.cpu_speed  (cpu_speed),
		.biu_done   (biu_done),
		.audio_ce   (audio_ce),
		.cpu_ce     (cpu_ce),
		.turbo_mode (turbo_mode)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output side
	splash_timer #(
		.SPLASH_TICK_CYCLES (SPLASH_TICK_CYCLES)
	) u_splash_timer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.splash_skip   (splash_skip),
		.splash_active (splash_active)
	);

endmodule

// ==== test/tb_checks.svh ====
/*
 * Testbench checks
 * Compare tasks per result kind and per-test error bookkeeping
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Running test and totals
string test_name = "none";
int    test_errors = 0;
int    total_errors = 0;
int    tests_run = 0;
int    tests_failed = 0;

task automatic start_test(input string name);
	test_name   = name;
	test_errors = 0;
endtask

// One line per finished test
task automatic finish_test();
	tests_run++;
	if (test_errors != 0)
		tests_failed++;
	$display("Test %s finished with %0d errors", test_name, test_errors);
endtask

task automatic count_error();
	test_errors++;
	total_errors++;
endtask

// Failures that are not a wrong value
task automatic report_failure(input string what);
	$display("Test %s went wrong: %s", test_name, what);
	count_error();
endtask

// Single-bit levels and strobes
task automatic check_bit(input string what, input logic exp, input logic act);
	if (act !== exp) begin
		$display("** Error %s: %s expected %b actual %b", test_name, what, exp, act);
		count_error();
	end
endtask

task automatic check_byte(input string what,
	input logic [pcxt_ctrl_pkg::ROM_BYTE_W-1:0] exp,
	input logic [pcxt_ctrl_pkg::ROM_BYTE_W-1:0] act);
	if (act !== exp) begin
		$display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
		count_error();
	end
endtask

task automatic check_addr(input string what,
	input logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0] exp,
	input logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0] act);
	if (act !== exp) begin
		$display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
		count_error();
	end
endtask

task automatic check_speed(input string what, input pcxt_ctrl_pkg::cpu_speed_t exp,
	input pcxt_ctrl_pkg::cpu_speed_t act);
	if (act !== exp) begin
		$display("** Error %s: %s expected %s actual %s (%0d)", test_name, what,
			exp.name(), act.name(), act);
		count_error();
	end
endtask

// Edge and pulse counts
task automatic check_count(input string what, input longint exp, input longint act);
	if (act != exp) begin
		$display("** Error %s: %s expected %0d actual %0d", test_name, what, exp, act);
		count_error();
	end
endtask

// Count within one of num/den
task automatic check_within_one(input string what, input longint num, input longint den,
	input longint act);
	if ((act * den < num - den) || (act * den > num + den)) begin
		$display("** Error %s: %s expected %.3f +/- 1 actual %0d", test_name, what,
			real'(num) / real'(den), act);
		count_error();
	end
endtask

`endif

// ==== test/tb_pcxt_system_ctrl.sv ====
/*
 * PC/XT system control testbench
 * Directed tests for reset, splash, model latch, download and enables
 */
`timescale 1ns/1ps

module tb_pcxt_system_ctrl;

	localparam int ADDR_W        = pcxt_ctrl_pkg::ROM_ADDR_W;
	localparam int WORD_W        = pcxt_ctrl_pkg::ROM_WORD_W;
	localparam int BYTE_W        = pcxt_ctrl_pkg::ROM_BYTE_W;
	localparam int SPLASH_TICKS  = 100;
	localparam int HOLD_CYCLES   = int'(pcxt_ctrl_pkg::RESET_HOLD_CYCLES);
	localparam int CPU_DELAY     = int'(pcxt_ctrl_pkg::CPU_RESET_DELAY);
	localparam int AUDIO_WINDOW  = 200_000;
	localparam int CPU_WINDOW    = 10_000;
	// Three reset-hold waits plus a spare, both rate windows and some slack
	localparam int TIMEOUT_CYCLES = 4 * (HOLD_CYCLES + 600) + AUDIO_WINDOW
		+ 3 * CPU_WINDOW + 20_000;

	logic                      CLK_50M;
	logic                      reset_wire;
	logic                      ioctl_wr;
	logic [ADDR_W-1:0]         ioctl_addr;
	logic [WORD_W-1:0]         ioctl_data;
	logic                      ioctl_wait;
	logic                      rom_wr;
	logic [ADDR_W-1:0]         rom_addr;
	logic [BYTE_W-1:0]         rom_data;
	logic                      splash_skip;
	logic                      menu_reset;
	logic                      model_tandy;
	pcxt_ctrl_pkg::cpu_speed_t cpu_speed;
	logic                      biu_done;
	logic                      splash_active;
	logic                      sys_reset;
	logic                      cpu_reset;
	logic                      tandy_mode;
	logic                      audio_ce;
	logic                      cpu_ce;
	logic                      turbo_mode;
	int                        cycle_count = 0;

	`include "tb_checks.svh"

	pcxt_system_ctrl #(
		.SPLASH_TICK_CYCLES (32'(SPLASH_TICKS))
	) dut (
		.CLK_50M (CLK_50M), .reset_wire (reset_wire),
		.ioctl_wr (ioctl_wr), .ioctl_addr (ioctl_addr), .ioctl_data (ioctl_data),
		.ioctl_wait (ioctl_wait), .rom_wr (rom_wr), .rom_addr (rom_addr),
		.rom_data (rom_data), .splash_skip (splash_skip), .menu_reset (menu_reset),
		.model_tandy (model_tandy), .cpu_speed (cpu_speed), .biu_done (biu_done),
		.splash_active (splash_active), .sys_reset (sys_reset), .cpu_reset (cpu_reset),
		.tandy_mode (tandy_mode), .audio_ce (audio_ce), .cpu_ce (cpu_ce),
		.turbo_mode (turbo_mode)
	);

	// 50 MHz
	always #10 CLK_50M = ~CLK_50M;

	// Watchdog
	always @(posedge CLK_50M) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles in test %s", cycle_count, test_name);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers, all return on a falling edge
	task automatic apply_reset();
		@(negedge CLK_50M);
		reset_wire = 1'b1;
		repeat (3) @(negedge CLK_50M);
		reset_wire = 1'b0;
	endtask

	task automatic wait_splash_fall(input int limit, output int edges);
		edges = 0;
		while (splash_active && edges < limit) begin
			@(negedge CLK_50M);
			edges++;
			check_bit("sys_reset while splash shows", 1'b1, sys_reset);
		end
		if (splash_active)
			report_failure("splash_active never fell");
	endtask

	// Edges until system reset drops, CPU must stay held
	task automatic measure_sys_hold(output int edges);
		edges = 0;
		while (sys_reset && edges < HOLD_CYCLES + 16) begin
			@(negedge CLK_50M);
			edges++;
			check_bit("cpu_reset during hold", 1'b1, cpu_reset);
		end
	endtask

	task automatic measure_cpu_delay(output int edges);
		edges = 0;
		while (cpu_reset && edges < CPU_DELAY + 16) begin
			@(negedge CLK_50M);
			edges++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	task automatic reset_release_test();
		int edges;
		start_test("reset_release");
		splash_skip = 1'b1;
		apply_reset();
		// Levels straight out of reset
		check_bit("sys_reset in reset", 1'b1, sys_reset);
		check_bit("cpu_reset in reset", 1'b1, cpu_reset);
		check_bit("splash_active in reset", 1'b1, splash_active);
		check_bit("rom_wr in reset", 1'b0, rom_wr);
		check_bit("ioctl_wait in reset", 1'b0, ioctl_wait);
		check_bit("audio_ce in reset", 1'b0, audio_ce);
		check_bit("cpu_ce in reset", 1'b0, cpu_ce);
		check_bit("turbo_mode in reset", 1'b0, turbo_mode);
		wait_splash_fall(16, edges);
		check_count("edges to splash skip", 1, edges);
		measure_sys_hold(edges);
		check_count("sys_reset hold edges", HOLD_CYCLES, edges);
		measure_cpu_delay(edges);
		check_count("cpu_reset delay edges", CPU_DELAY, edges);
		// Menu reset raises both on the next edge
		menu_reset = 1'b1;
		@(negedge CLK_50M);
		menu_reset = 1'b0;
		check_bit("sys_reset after menu_reset", 1'b1, sys_reset);
		check_bit("cpu_reset after menu_reset", 1'b1, cpu_reset);
		finish_test();
	endtask

	task automatic splash_hold_test();
		int edges;
		start_test("splash_hold");
		splash_skip = 1'b0;
		apply_reset();
		wait_splash_fall(int'(pcxt_ctrl_pkg::SPLASH_SECONDS) * SPLASH_TICKS + 16, edges);
		check_count("splash edges", int'(pcxt_ctrl_pkg::SPLASH_SECONDS) * SPLASH_TICKS, edges);
		measure_sys_hold(edges);
		check_count("sys_reset hold after splash", HOLD_CYCLES, edges);
		finish_test();
	endtask

	task automatic model_latch_test();
		int edges;
		start_test("model_latch");
		splash_skip = 1'b1;
		model_tandy = 1'b1;
		apply_reset();
		@(negedge CLK_50M);
		check_bit("tandy_mode during reset", 1'b1, tandy_mode);
		measure_sys_hold(edges);
		// Switch moved while the machine runs
		model_tandy = 1'b0;
		repeat (20) @(negedge CLK_50M);
		check_bit("tandy_mode held while running", 1'b1, tandy_mode);
		menu_reset = 1'b1;
		@(negedge CLK_50M);
		menu_reset = 1'b0;
		@(negedge CLK_50M);
		check_bit("tandy_mode after menu_reset", 1'b0, tandy_mode);
		finish_test();
	endtask

	task automatic rom_download_test();
		logic [ADDR_W-1:0] word_addr;
		logic [WORD_W-1:0] word_data;
		int                hold;
		int                writes;
		start_test("rom_download");
		apply_reset();
		for (int i = 0; i < 6; i++) begin
			// Addresses cross a 1 MB boundary on the way
			word_addr = 25'h0F_FFFE + ADDR_W'(2 * i);
			word_data = 16'hA55A + 16'(i) * 16'h1357;
			hold      = (i % 5) + 1;
			writes    = 0;
			check_bit("ioctl_wait before word", 1'b0, ioctl_wait);
			ioctl_addr = word_addr;
			ioctl_data = word_data;
			ioctl_wr   = 1'b1;
			for (int c = 0; c < hold + 6; c++) begin
				@(negedge CLK_50M);
				if (rom_wr) begin
					check_bit("ioctl_wait with rom_wr", 1'b1, ioctl_wait);
					if (writes == 0) begin
						check_addr("low byte address", word_addr, rom_addr);
						check_byte("low byte data", word_data[BYTE_W-1:0], rom_data);
					end else if (writes == 1) begin
						check_addr("high byte address", word_addr + ADDR_W'(1), rom_addr);
						check_byte("high byte data", word_data[WORD_W-1:BYTE_W], rom_data);
					end
					writes++;
				end
				if (c + 1 == hold)
					ioctl_wr = 1'b0;
			end
			if (writes != 2)
				report_failure($sformatf("word %0d held %0d cycles gave %0d byte writes, state %s",
					i, hold, writes, dut.u_download_splitter.dl_state.name()));
		end
		finish_test();
	endtask

	task automatic audio_rate_test();
		longint pulses;
		start_test("audio_rate");
		pulses = 0;
		apply_reset();
		repeat (AUDIO_WINDOW) begin
			@(negedge CLK_50M);
			if (audio_ce)
				pulses++;
		end
		check_count("audio_ce pulses", longint'(AUDIO_WINDOW)
			* longint'(pcxt_ctrl_pkg::AUDIO_RATE_HZ) / longint'(pcxt_ctrl_pkg::SYS_CLOCK_HZ),
			pulses);
		finish_test();
	endtask

	task automatic cpu_speed_change_test();
		longint pulses;
		start_test("cpu_speed_change");
		biu_done  = 1'b0;
		cpu_speed = pcxt_ctrl_pkg::SPEED_14M318;
		pulses    = 0;
		apply_reset();
		repeat (CPU_WINDOW) begin
			@(negedge CLK_50M);
			if (cpu_ce)
				pulses++;
		end
		// No bus cycle done, still at 4.77 MHz
		check_count("cpu_ce pulses at 4.77 MHz", longint'(CPU_WINDOW)
			* longint'(pcxt_ctrl_pkg::CPU_RATE_4M77_HZ)
			/ longint'(pcxt_ctrl_pkg::SYS_CLOCK_HZ), pulses);
		check_bit("turbo_mode before biu_done", 1'b0, turbo_mode);
		check_speed("speed before biu_done", pcxt_ctrl_pkg::SPEED_4M77,
			dut.u_clock_enable_gen.speed_q);
		biu_done = 1'b1;
		@(negedge CLK_50M);
		biu_done = 1'b0;
		check_bit("turbo_mode after biu_done", 1'b1, turbo_mode);
		check_speed("speed after biu_done", pcxt_ctrl_pkg::SPEED_14M318,
			dut.u_clock_enable_gen.speed_q);
		pulses = 0;
		repeat (CPU_WINDOW) begin
			@(negedge CLK_50M);
			if (cpu_ce)
				pulses++;
		end
		check_within_one("cpu_ce pulses at 14.318 MHz", longint'(CPU_WINDOW)
			* longint'(pcxt_ctrl_pkg::CPU_RATE_14M318_HZ),
			longint'(pcxt_ctrl_pkg::SYS_CLOCK_HZ), pulses);
		finish_test();
	endtask

	////////////////////////////////////////////////////////////////////////////
	initial begin
		CLK_50M     = 1'b0;
		reset_wire  = 1'b1;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_data  = '0;
		splash_skip = 1'b0;
		menu_reset  = 1'b0;
		model_tandy = 1'b0;
		cpu_speed   = pcxt_ctrl_pkg::SPEED_4M77;
		biu_done    = 1'b0;
		reset_release_test();
		splash_hold_test();
		model_latch_test();
		rom_download_test();
		audio_rate_test();
		cpu_speed_change_test();
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+test
logic/pcxt_ctrl_pkg.sv
logic/rom_download_splitter.sv
logic/reset_sequencer.sv
logic/clock_enable_gen.sv
logic/splash_timer.sv
logic/pcxt_system_ctrl.sv
test/tb_pcxt_system_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the PC/XT system control testbench

VERILATOR ?= verilator
TOP       ?= tb_pcxt_system_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Result: FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
